//--- design/simd_alu_params.svh
// SIMD ALU slice widths, counts and field sizes
`ifndef SIMD_ALU_PARAMS_SVH
`define SIMD_ALU_PARAMS_SVH

// Datapath word
`define SIMD_ALU_ELEN 64

// Bytes per word, also the mask and saturation width
`define SIMD_ALU_STRB 8

// Element widths 8, 16, 32 and 64
`define SIMD_ALU_NUM_EW 4
`define SIMD_ALU_EW_W 2

// Shift amount, wide enough for a 64-bit lane
`define SIMD_ALU_SHAMT_W 6

// Opcode, class and sub-function fields
`define SIMD_ALU_OP_W 5
`define SIMD_ALU_CLS_W 3
`define SIMD_ALU_SEL_W 2

// Decode FSM
`define SIMD_ALU_STATE_W 2

`endif

//--- design/simd_alu_pkg.sv
// Shared data types, opcodes and state encodings of the SIMD ALU slice
`default_nettype none
`include "simd_alu_params.svh"

package simd_alu_pkg;

  typedef logic [`SIMD_ALU_ELEN-1:0]    elen_t;
  typedef logic [`SIMD_ALU_STRB-1:0]    strb_t;
  // One bit per byte, a saturated lane sets all of its bytes
  typedef logic [`SIMD_ALU_STRB-1:0]    vxsat_t;
  typedef logic [`SIMD_ALU_SHAMT_W-1:0] shamt_t;

  typedef enum logic [`SIMD_ALU_EW_W-1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  typedef enum logic [`SIMD_ALU_OP_W-1:0] {
    VAND, VOR, VXOR,
    VADD, VSUB, VRSUB,
    VSADDU, VSADD, VSSUBU, VSSUB,
    VSLL, VSRL, VSRA,
    VMIN, VMINU, VMAX, VMAXU,
    VMSEQ, VMSNE, VMSLT, VMSLTU, VMSLE, VMSLEU, VMSGT, VMSGTU,
    VMERGE
  } alu_op_e;

  typedef enum logic [`SIMD_ALU_CLS_W-1:0] {
    CLS_LOGIC,
    CLS_ADDSUB,
    CLS_SAT,
    CLS_SHIFT,
    CLS_MINMAX,
    CLS_CMP,
    CLS_MERGE
  } op_class_e;

  typedef enum logic [`SIMD_ALU_STATE_W-1:0] {
    DEC_IDLE,
    DEC_ISSUE,
    DEC_ACK
  } dec_state_e;

endpackage : simd_alu_pkg

`default_nettype wire

//--- design/simd_alu_decode.sv
// SIMD ALU decode stage: four-phase handshake FSM, operand capture, opcode decode
`timescale 1ns/10ps
`default_nettype none
`include "simd_alu_params.svh"

module simd_alu_decode import simd_alu_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       req_i,
  input  alu_op_e                    op_i,
  input  vew_e                       vew_i,
  input  elen_t                      operand_a_i,
  input  elen_t                      operand_b_i,
  input  strb_t                      mask_i,
  output logic                       ack_o,
  output logic                       issue_o,
  output elen_t                      opa_o,
  output elen_t                      opb_o,
  output strb_t                      mask_o,
  output vew_e                       vew_o,
  output op_class_e                  op_class_o,
  output logic                       is_signed_o,
  output logic                       is_sub_o,
  output logic                       swap_o,
  output logic                       is_max_o,
  output logic                       negate_o,
  output logic                       or_equal_o,
  output logic [`SIMD_ALU_SEL_W-1:0] logic_sel_o
);

  dec_state_e                 state_q;
  dec_state_e                 state_d;
  logic                       accept;
  op_class_e                  class_d;
  logic [`SIMD_ALU_SEL_W-1:0] logic_sel_d;

  ////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      DEC_IDLE:  if (req_i) state_d = DEC_ISSUE;
      DEC_ISSUE: state_d = DEC_ACK;
      // Hold ack until the requester lets go
      DEC_ACK:   if (!req_i) state_d = DEC_IDLE;
      default:   state_d = DEC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= DEC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign accept  = (state_q == DEC_IDLE) & req_i;
  assign issue_o = (state_q == DEC_ISSUE);
  assign ack_o   = (state_q == DEC_ACK);

  ////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////

  always_comb begin
    case (op_i)
      VAND, VOR, VXOR:                class_d = CLS_LOGIC;
      VADD, VSUB, VRSUB:              class_d = CLS_ADDSUB;
      VSADDU, VSADD, VSSUBU, VSSUB:   class_d = CLS_SAT;
      VSLL, VSRL, VSRA:               class_d = CLS_SHIFT;
      VMIN, VMINU, VMAX, VMAXU:       class_d = CLS_MINMAX;
      VMSEQ, VMSNE, VMSLT, VMSLTU,
      VMSLE, VMSLEU, VMSGT, VMSGTU:   class_d = CLS_CMP;
      VMERGE:                         class_d = CLS_MERGE;
      default:                        class_d = CLS_LOGIC;
    endcase
  end

  // Sub-function select, shared by logic, shift and compare classes
  // 00 and/sll/ordered, 01 or/srl/equality, 10 xor/sra
  assign logic_sel_d = {op_i inside {VXOR, VSRA}, op_i inside {VOR, VSRL, VMSEQ, VMSNE}};

  ////////////////////////////////////////
  // Capture on acceptance
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      opa_o       <= operand_a_i;
      opb_o       <= operand_b_i;
      mask_o      <= mask_i;
      vew_o       <= vew_i;
      op_class_o  <= class_d;
      is_signed_o <= op_i inside {VSADD, VSSUB, VMIN, VMAX, VMSLT, VMSLE, VMSGT};
      is_sub_o    <= op_i inside {VSUB, VRSUB, VSSUBU, VSSUB};
      swap_o      <= (op_i == VRSUB);
      is_max_o    <= op_i inside {VMAX, VMAXU};
      negate_o    <= op_i inside {VMSNE, VMSGT, VMSGTU};
      or_equal_o  <= op_i inside {VMSLE, VMSLEU, VMSGT, VMSGTU};
      logic_sel_o <= logic_sel_d;
    end
  end

endmodule : simd_alu_decode

`default_nettype wire

//--- design/simd_alu_compare.sv
// SIMD ALU per-lane less-than and equality detection for every element width
`timescale 1ns/10ps
`default_nettype none
`include "simd_alu_params.svh"

module simd_alu_compare import simd_alu_pkg::*; (
  input  elen_t opa_i,
  input  elen_t opb_i,
  input  vew_e  vew_i,
  input  logic  is_signed_i,
  output strb_t less_o,
  output strb_t equal_o
);

  // One flag vector per element width
  strb_t [`SIMD_ALU_NUM_EW-1:0] less_w;
  strb_t [`SIMD_ALU_NUM_EW-1:0] equal_w;

  for (genvar w = 0; w < `SIMD_ALU_NUM_EW; w++) begin : g_ew
    localparam int unsigned W  = 8 << w;
    localparam int unsigned LB = W / 8;

    for (genvar l = 0; l < `SIMD_ALU_STRB / LB; l++) begin : g_lane
      logic [W-1:0] a;
      logic [W-1:0] b;
      logic         a_ext;
      logic         b_ext;

      assign a = opa_i[W*l +: W];
      assign b = opb_i[W*l +: W];

      // Extra top bit folds signed and unsigned into one compare
      assign a_ext = is_signed_i & a[W-1];
      assign b_ext = is_signed_i & b[W-1];

      // B is the left-hand value
      assign less_w[w][LB*l]  = $signed({b_ext, b}) < $signed({a_ext, a});
      assign equal_w[w][LB*l] = (a == b);

      // Flag sits in the lowest byte bit only
      if (LB > 1) begin : g_pad
        assign less_w[w][LB*l+1 +: LB-1]  = '0;
        assign equal_w[w][LB*l+1 +: LB-1] = '0;
      end
    end
  end

  assign less_o  = less_w[vew_i];
  assign equal_o = equal_w[vew_i];

endmodule : simd_alu_compare

`default_nettype wire

//--- design/simd_alu_execute.sv
// SIMD ALU execute stage: per-lane logic, arithmetic, saturation, shift, min/max, compare, merge
`timescale 1ns/10ps
`default_nettype none
`include "simd_alu_params.svh"

module simd_alu_execute import simd_alu_pkg::*; (
  input  elen_t                      opa_i,
  input  elen_t                      opb_i,
  input  strb_t                      mask_i,
  input  vew_e                       vew_i,
  input  op_class_e                  op_class_i,
  input  logic                       is_signed_i,
  input  logic                       is_sub_i,
  input  logic                       swap_i,
  input  logic                       is_max_i,
  input  logic                       negate_i,
  input  logic                       or_equal_i,
  input  logic [`SIMD_ALU_SEL_W-1:0] logic_sel_i,
  output elen_t                      res_o,
  output vxsat_t                     sat_o
);

  strb_t                         less;
  strb_t                         equal;
  elen_t  [`SIMD_ALU_NUM_EW-1:0] res_w;
  vxsat_t [`SIMD_ALU_NUM_EW-1:0] sat_w;

  simd_alu_compare i_compare (
    .opa_i       (opa_i),
    .opb_i       (opb_i),
    .vew_i       (vew_i),
    .is_signed_i (is_signed_i),
    .less_o      (less),
    .equal_o     (equal)
  );

  ////////////////////////////////////////
  // Lane datapath, one copy per width
  ////////////////////////////////////////

  // Each lane is moved to the top of a 64-bit word so that carries,
  // overflow and sign all sit at fixed bit positions
  for (genvar w = 0; w < `SIMD_ALU_NUM_EW; w++) begin : g_ew
    localparam int unsigned W  = 8 << w;
    localparam int unsigned LB = W / 8;
    localparam int unsigned SH = `SIMD_ALU_ELEN - W;

    for (genvar l = 0; l < `SIMD_ALU_STRB / LB; l++) begin : g_lane
      elen_t                 a_al;
      elen_t                 b_al;
      elen_t                 lhs;
      elen_t                 rhs;
      logic [`SIMD_ALU_ELEN:0] as_x;
      logic                  ovf;
      logic                  sat;
      elen_t                 clamp;
      shamt_t                shamt;
      elen_t                 logic_res;
      elen_t                 sra_res;
      logic                  cmp_bit;
      elen_t                 lane;

      assign a_al = elen_t'(opa_i[W*l +: W]) << SH;
      assign b_al = elen_t'(opb_i[W*l +: W]) << SH;

      // B minus A unless reversed
      assign lhs  = swap_i ? a_al : b_al;
      assign rhs  = swap_i ? b_al : a_al;
      assign as_x = is_sub_i ? {1'b0, lhs} - {1'b0, rhs} : {1'b0, lhs} + {1'b0, rhs};

      // Signed overflow: operand signs agree (add) or differ (sub), result sign flips
      assign ovf = ((lhs[`SIMD_ALU_ELEN-1] ~^ rhs[`SIMD_ALU_ELEN-1]) ^ is_sub_i) &
                   (as_x[`SIMD_ALU_ELEN-1] ^ lhs[`SIMD_ALU_ELEN-1]);
      // Unsigned uses carry out or borrow
      assign sat = is_signed_i ? ovf : as_x[`SIMD_ALU_ELEN];

      assign clamp = is_signed_i ?
                     (lhs[`SIMD_ALU_ELEN-1] ? {1'b1, {(`SIMD_ALU_ELEN-1){1'b0}}}
                                            : {1'b0, {(`SIMD_ALU_ELEN-1){1'b1}}}) :
                     {`SIMD_ALU_ELEN{~is_sub_i}};

      // Amount from the low bits of the A lane
      assign shamt   = shamt_t'(opa_i[W*l +: $clog2(W)]);
      assign sra_res = $signed(b_al) >>> shamt;

      assign logic_res = (logic_sel_i == 2'b00) ? (a_al & b_al) :
                         (logic_sel_i == 2'b01) ? (a_al | b_al) : (a_al ^ b_al);

      assign cmp_bit = logic_sel_i[0] ? (equal[LB*l] ^ negate_i) :
                       ((less[LB*l] | (equal[LB*l] & or_equal_i)) ^ negate_i);

      always_comb begin
        case (op_class_i)
          CLS_LOGIC:  lane = logic_res;
          CLS_ADDSUB: lane = as_x[`SIMD_ALU_ELEN-1:0];
          CLS_SAT:    lane = sat ? clamp : as_x[`SIMD_ALU_ELEN-1:0];
          CLS_SHIFT:  lane = (logic_sel_i == 2'b00) ? (b_al << shamt) :
                             (logic_sel_i == 2'b01) ? (b_al >> shamt) : sra_res;
          CLS_MINMAX: lane = (less[LB*l] ^ is_max_i) ? b_al : a_al;
          // {mask, result} in the two low bits of the lane
          CLS_CMP:    lane = elen_t'({mask_i[LB*l], cmp_bit}) << SH;
          CLS_MERGE:  lane = mask_i[LB*l] ? a_al : b_al;
          default:    lane = '0;
        endcase
      end

      assign res_w[w][W*l +: W]  = lane[`SIMD_ALU_ELEN-1 -: W];
      assign sat_w[w][LB*l +: LB] = {LB{sat & (op_class_i == CLS_SAT)}};
    end
  end

  assign res_o = res_w[vew_i];
  assign sat_o = sat_w[vew_i];

endmodule : simd_alu_execute

`default_nettype wire

//--- design/simd_alu_result.sv
// SIMD ALU result stage: result register and sticky saturation flag
`timescale 1ns/10ps
`default_nettype none
`include "simd_alu_params.svh"

module simd_alu_result import simd_alu_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   issue_i,
  input  elen_t  res_i,
  input  vxsat_t sat_i,
  input  logic   clr_vxsat_i,
  output elen_t  result_o,
  output logic   vxsat_o
);

  ////////////////////////////////////////
  // Result register
  ////////////////////////////////////////

  // Held until the next accepted request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_o <= '0;
    end else if (issue_i) begin
      result_o <= res_i;
    end
  end

  ////////////////////////////////////////
  // Sticky saturation
  ////////////////////////////////////////

  // New saturation beats a clear on the same edge
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vxsat_o <= 1'b0;
    end else if (issue_i && (|sat_i)) begin
      vxsat_o <= 1'b1;
    end else if (clr_vxsat_i) begin
      vxsat_o <= 1'b0;
    end
  end

endmodule : simd_alu_result

`default_nettype wire

//--- design/simd_alu_top.sv
// SIMD ALU slice top level: decode, execute and result stages behind a req/ack handshake
`timescale 1ns/10ps
`default_nettype none
`include "simd_alu_params.svh"

module simd_alu_top import simd_alu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    req_i,
  input  alu_op_e op_i,
  input  vew_e    vew_i,
  input  elen_t   operand_a_i,
  input  elen_t   operand_b_i,
  input  strb_t   mask_i,
  input  logic    clr_vxsat_i,
  output logic    ack_o,
  output elen_t   result_o,
  output logic    vxsat_o
);

  logic                       issue;
  elen_t                      opa;
  elen_t                      opb;
  strb_t                      mask;
  vew_e                       vew;
  op_class_e                  op_class;
  logic                       is_signed;
  logic                       is_sub;
  logic                       swap;
  logic                       is_max;
  logic                       negate;
  logic                       or_equal;
  logic [`SIMD_ALU_SEL_W-1:0] logic_sel;
  elen_t                      res;
  vxsat_t                     sat;

  simd_alu_decode i_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .mask_i      (mask_i),
    .ack_o       (ack_o),
    .issue_o     (issue),
    .opa_o       (opa),
    .opb_o       (opb),
    .mask_o      (mask),
    .vew_o       (vew),
    .op_class_o  (op_class),
    .is_signed_o (is_signed),
    .is_sub_o    (is_sub),
    .swap_o      (swap),
    .is_max_o    (is_max),
    .negate_o    (negate),
    .or_equal_o  (or_equal),
    .logic_sel_o (logic_sel)
  );

  simd_alu_execute i_execute (
    .opa_i       (opa),
    .opb_i       (opb),
    .mask_i      (mask),
    .vew_i       (vew),
    .op_class_i  (op_class),
    .is_signed_i (is_signed),
    .is_sub_i    (is_sub),
    .swap_i      (swap),
    .is_max_i    (is_max),
    .negate_i    (negate),
    .or_equal_i  (or_equal),
    .logic_sel_i (logic_sel),
    .res_o       (res),
    .sat_o       (sat)
  );

  simd_alu_result i_result (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .issue_i     (issue),
    .res_i       (res),
    .sat_i       (sat),
    .clr_vxsat_i (clr_vxsat_i),
    .result_o    (result_o),
    .vxsat_o     (vxsat_o)
  );

endmodule : simd_alu_top

`default_nettype wire

//--- tb/simd_alu_assertions.sv
// SIMD ALU handshake and reset checks, bound into the top level
`timescale 1ns/10ps
`default_nettype none

module simd_alu_assertions (
  input logic clk_i,
  input logic rst_n_i,
  input logic req_i,
  input logic ack_i
);

  ////////////////////////////////////////
  // Reset
  ////////////////////////////////////////

  ack_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !ack_i)
    else $error("ack high while reset is asserted");

  ////////////////////////////////////////
  // Four-phase handshake
  ////////////////////////////////////////

  // Req first seen high three edges back, held since
  ack_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ack_i) |-> $past(req_i, 1) && $past(req_i, 2) && !$past(req_i, 3))
    else $error("ack did not rise two edges after acceptance");

  ack_release: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_i && !req_i |=> !ack_i)
    else $error("ack did not fall one edge after req dropped");

  ack_without_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !ack_i && !req_i |=> !ack_i)
    else $error("ack rose while req was low");

  // Back-pressure
  ack_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_i && req_i |=> ack_i)
    else $error("ack dropped while req was still held");

endmodule : simd_alu_assertions

bind simd_alu_top simd_alu_assertions i_assertions (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .req_i   (req_i),
  .ack_i   (ack_o)
);

`default_nettype wire

//--- tb/simd_alu_tb.sv
// SIMD ALU slice testbench: directed handshake, arithmetic, saturation, shift and compare tests
`timescale 1ns/10ps
`default_nettype none
`include "simd_alu_params.svh"

module simd_alu_tb import simd_alu_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int N_TXN        = 379;
  localparam int WATCHDOG_CYC = N_TXN * 10 + RESET_CYCLES;

  logic    clk_i;
  logic    rst_n_i;
  logic    req_i;
  alu_op_e op_i;
  vew_e    vew_i;
  elen_t   operand_a_i;
  elen_t   operand_b_i;
  strb_t   mask_i;
  logic    clr_vxsat_i;
  logic    ack_o;
  elen_t   result_o;
  logic    vxsat_o;
  logic    exp_vxsat;

  simd_alu_top uut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .mask_i      (mask_i),
    .clr_vxsat_i (clr_vxsat_i),
    .ack_o       (ack_o),
    .result_o    (result_o),
    .vxsat_o     (vxsat_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    report_failure("timeout: the tests did not finish in the allowed time");
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input elen_t got, input elen_t expected, input string what);
    if (got !== expected) begin
      report_failure($sformatf("mismatch at %0t ns: %s got %h expected %h",
                               $time, what, got, expected));
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic elen_t lane_mask(input vew_e ew);
    int w;
    w = 8 << ew;
    return (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
  endfunction

  // Same value in every lane
  function automatic elen_t fill(input vew_e ew, input elen_t v);
    int    w;
    elen_t r;
    w = 8 << ew;
    r = '0;
    for (int l = 0; l < 64 / w; l++) r = r | ((v & lane_mask(ew)) << (w * l));
    return r;
  endfunction

  function automatic elen_t ref_result(input alu_op_e op, input vew_e ew, input elen_t a,
                                       input elen_t b, input strb_t m, output logic sat);
    int                 w;
    int                 lane_bytes;
    int                 sh;
    elen_t              lm;
    elen_t              la;
    elen_t              lbv;
    elen_t              lr;
    elen_t              r;
    logic signed [63:0] xa;
    logic signed [63:0] xb;
    logic signed [65:0] sa;
    logic signed [65:0] sb;
    logic signed [65:0] sr;
    logic signed [65:0] smax;
    logic signed [65:0] smin;
    logic        [65:0] ur;
    logic               less;
    logic               eq;
    logic               lsat;
    w          = 8 << ew;
    lane_bytes = w / 8;
    lm         = lane_mask(ew);
    smax       = {2'b00, lm >> 1};
    smin       = -smax - 66'sd1;
    r          = '0;
    sat        = 1'b0;
    for (int l = 0; l < 64 / w; l++) begin
      la   = (a >> (w * l)) & lm;
      lbv  = (b >> (w * l)) & lm;
      xa   = la << (64 - w);
      xa   = xa >>> (64 - w);
      xb   = lbv << (64 - w);
      xb   = xb >>> (64 - w);
      sa   = {{2{xa[63]}}, xa};
      sb   = {{2{xb[63]}}, xb};
      sh   = int'(la & elen_t'(w - 1));
      eq   = (la == lbv);
      // B is the left-hand value of every compare
      less = (op inside {VMIN, VMAX, VMSLT, VMSLE, VMSGT}) ? (xb < xa) : (lbv < la);
      lsat = 1'b0;
      sr   = (op == VSSUB) ? (sb - sa) : (sb + sa);
      case (op)
        VAND:   lr = la & lbv;
        VOR:    lr = la | lbv;
        VXOR:   lr = la ^ lbv;
        VADD:   lr = la + lbv;
        VSUB:   lr = lbv - la;
        VRSUB:  lr = la - lbv;
        VSADDU: begin
          ur   = {2'b00, lbv} + {2'b00, la};
          lsat = (ur > {2'b00, lm});
          lr   = lsat ? lm : ur[63:0];
        end
        VSSUBU: begin
          lsat = (lbv < la);
          lr   = lsat ? '0 : lbv - la;
        end
        VSADD, VSSUB: begin
          lsat = (sr > smax) || (sr < smin);
          lr   = (sr > smax) ? smax[63:0] : (sr < smin) ? smin[63:0] : sr[63:0];
        end
        VSLL:          lr = lbv << sh;
        VSRL:          lr = lbv >> sh;
        VSRA:          lr = xb >>> sh;
        VMIN, VMINU:   lr = less ? lbv : la;
        VMAX, VMAXU:   lr = less ? la : lbv;
        VMSEQ:         lr = {62'd0, m[l * lane_bytes], eq};
        VMSNE:         lr = {62'd0, m[l * lane_bytes], !eq};
        VMSLT, VMSLTU: lr = {62'd0, m[l * lane_bytes], less};
        VMSLE, VMSLEU: lr = {62'd0, m[l * lane_bytes], less | eq};
        VMSGT, VMSGTU: lr = {62'd0, m[l * lane_bytes], !(less | eq)};
        default:       lr = m[l * lane_bytes] ? la : lbv;
      endcase
      r   = r | ((lr & lm) << (w * l));
      sat = sat | lsat;
    end
    return r;
  endfunction

  ////////////////////////////////////////
  // Transaction and tests
  ////////////////////////////////////////

  // One full four-phase transfer, req held for hold extra cycles
  task automatic do_op(input alu_op_e op, input vew_e ew, input elen_t a, input elen_t b,
                       input strb_t m, input int hold);
    elen_t exp_res;
    logic  exp_sat;
    int    edges;
    string tag;
    exp_res = ref_result(op, ew, a, b, m, exp_sat);
    if (exp_sat) exp_vxsat = 1'b1;
    tag = $sformatf("%s ew%0d", op.name(), 8 << ew);
    @(negedge clk_i);
    op_i        = op;
    vew_i       = ew;
    operand_a_i = a;
    operand_b_i = b;
    mask_i      = m;
    req_i       = 1'b1;
    edges       = 0;
    while (!ack_o && edges < 8) begin
      @(negedge clk_i);
      edges++;
    end
    if (!ack_o) report_failure("no acknowledge from the DUT within 8 cycles");
    check(elen_t'(edges), 64'd2, {tag, " ack latency"});
    repeat (hold) begin
      @(negedge clk_i);
      check(elen_t'(ack_o), 64'd1, {tag, " ack under back-pressure"});
    end
    check(result_o, exp_res, {tag, " result"});
    check(elen_t'(vxsat_o), elen_t'(exp_vxsat), {tag, " vxsat"});
    req_i       = 1'b0;
    operand_a_i = ~a;
    @(negedge clk_i);
    check(elen_t'(ack_o), 64'd0, {tag, " ack release"});
    check(result_o, exp_res, {tag, " result hold"});
  endtask

  task automatic run_random(input alu_op_e op, input bit near_equal);
    elen_t a;
    elen_t b;
    strb_t m;
    for (int w = 0; w < 4; w++) begin
      for (int i = 0; i < 4; i++) begin
        a = {$urandom, $urandom};
        b = {$urandom, $urandom};
        // Whole word equal on the second pass
        if (near_equal && i == 1) b = a;
        // Sparse flips on the last pass leave many small lanes equal
        if (near_equal && i == 3) b = a ^ (b & {$urandom, $urandom} & {$urandom, $urandom});
        m = 8'($urandom);
        do_op(op, vew_e'(w), a, b, m, 0);
      end
    end
  endtask

  task automatic clear_vxsat;
    @(negedge clk_i);
    clr_vxsat_i = 1'b1;
    @(negedge clk_i);
    clr_vxsat_i = 1'b0;
    exp_vxsat   = 1'b0;
    check(elen_t'(vxsat_o), 64'd0, "vxsat clear");
  endtask

  // Flag starts clear, so this op alone has to set it
  task automatic clamp_case(input alu_op_e op, input vew_e ew, input elen_t a, input elen_t b,
                            input elen_t clamped);
    string tag;
    tag = $sformatf("%s ew%0d", op.name(), 8 << ew);
    clear_vxsat();
    do_op(op, ew, a, b, 8'h00, 0);
    check(result_o, clamped, {tag, " clamp"});
    check(elen_t'(vxsat_o), 64'd1, {tag, " vxsat set"});
  endtask

  task automatic handshake_timing;
    do_op(VADD, EW32, {$urandom, $urandom}, {$urandom, $urandom}, 8'h00, 5);
    do_op(VXOR, EW8, {$urandom, $urandom}, {$urandom, $urandom}, 8'h00, 0);
  endtask

  task automatic logic_and_arith;
    run_random(VAND, 1'b0);
    run_random(VOR, 1'b0);
    run_random(VXOR, 1'b0);
    run_random(VADD, 1'b0);
    run_random(VSUB, 1'b0);
    run_random(VRSUB, 1'b0);
  endtask

  task automatic saturation_clamps;
    vew_e  ew;
    elen_t ones;
    elen_t one;
    elen_t smax_w;
    elen_t smin_w;
    ones = '1;
    for (int w = 0; w < 4; w++) begin
      ew     = vew_e'(w);
      one    = fill(ew, 64'd1);
      smax_w = fill(ew, lane_mask(ew) >> 1);
      smin_w = ones ^ smax_w;
      clamp_case(VSADDU, ew, ones, one, ones);
      clamp_case(VSADD, ew, one, smax_w, smax_w);
      clamp_case(VSADD, ew, ones, smin_w, smin_w);
      clamp_case(VSSUBU, ew, one, '0, '0);
      clamp_case(VSSUB, ew, one, smin_w, smin_w);
      clamp_case(VSSUB, ew, ones, smax_w, smax_w);
    end
    // Sticky through a plain op, then cleared
    do_op(VAND, EW16, {$urandom, $urandom}, {$urandom, $urandom}, 8'h00, 0);
    check(elen_t'(vxsat_o), 64'd1, "vxsat sticky");
    clear_vxsat();
  endtask

  task automatic shifts_and_minmax;
    run_random(VSLL, 1'b0);
    run_random(VSRL, 1'b0);
    run_random(VSRA, 1'b0);
    run_random(VMIN, 1'b1);
    run_random(VMINU, 1'b1);
    run_random(VMAX, 1'b1);
    run_random(VMAXU, 1'b1);
  endtask

  task automatic compares_and_merge;
    run_random(VMSEQ, 1'b1);
    run_random(VMSNE, 1'b1);
    run_random(VMSLT, 1'b1);
    run_random(VMSLTU, 1'b1);
    run_random(VMSLE, 1'b1);
    run_random(VMSLEU, 1'b1);
    run_random(VMSGT, 1'b1);
    run_random(VMSGTU, 1'b1);
    run_random(VMERGE, 1'b0);
  endtask

  initial begin
    void'($urandom(32'h2ac49906));
    rst_n_i     = 1'b0;
    req_i       = 1'b0;
    op_i        = VAND;
    vew_i       = EW8;
    operand_a_i = '0;
    operand_b_i = '0;
    mask_i      = '0;
    clr_vxsat_i = 1'b0;
    exp_vxsat   = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;
    check(elen_t'(ack_o), 64'd0, "ack after reset");
    check(result_o, '0, "result after reset");
    check(elen_t'(vxsat_o), 64'd0, "vxsat after reset");
    handshake_timing();
    logic_and_arith();
    saturation_clamps();
    shifts_and_minmax();
    compares_and_merge();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule : simd_alu_tb

`default_nettype wire

//--- simd_alu.f
+incdir+design
design/simd_alu_pkg.sv
design/simd_alu_decode.sv
design/simd_alu_compare.sv
design/simd_alu_execute.sv
design/simd_alu_result.sv
design/simd_alu_top.sv
tb/simd_alu_assertions.sv
tb/simd_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SIMD ALU testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/simd_alu_sim

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module simd_alu_tb -f simd_alu.f -o simd_alu_sim
if [ $? -ne 0 ]; then
  echo "FAIL: Verilator build did not complete"
  exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
  echo "FAIL: simulator exited with status $status"
  exit 1
fi
if grep -q "Simulation failed" "$LOG"; then
  echo "FAIL: testbench reported an error"
  exit 1
fi
echo "PASS"
exit 0
